//--- rtl/excCtrl_settings.svh
`ifndef EXC_CTRL_SETTINGS_SVH
`define EXC_CTRL_SETTINGS_SVH

// APB address width for the exception register block
`define EXC_APB_ADDR_W 4

// Register offsets, word aligned
`define EXC_REG_CTRL  4'h0
`define EXC_REG_CAUSE 4'h4
`define EXC_REG_COUNT 4'h8

// Exception entry counter width
`define EXC_COUNT_W 8

`endif

//--- rtl/excPkg.sv
`include "excCtrl_settings.svh"

package excPkg;

  // Flush and stall bundle to the pipeline
  typedef struct packed {
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
    logic stallD;
  } excFlush_t;

  // Named cause flags, MSB first
  // Bit 0 is the reset cause
  typedef struct packed {
    logic fiq;
    logic irq;
    logic dataAbort;
    logic prefetchAbort;
    logic swi;
    logic undef;
    logic reset;
  } excCause_t;

  // Cause vector, seen as flags or as a raw word
  typedef union packed {
    excCause_t  cause;
    logic [6:0] bits;
  } excVector_u;

  // APB request from the bus master
  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`EXC_APB_ADDR_W-1:0] paddr;
    logic [31:0]                pwdata;
  } apbReq_t;

endpackage

//--- rtl/exceptionHandler.sv
`timescale 1ns/1ps

module exceptionHandler (
  input  logic              clk,
  input  logic              rstN,
  input  logic              undefinedInstrE,
  input  logic              swiE,
  input  logic              prefetchAbortE,
  input  logic              dataAbort,
  input  logic              irq,
  input  logic              fiq,
  input  logic              irqEn,
  input  logic              fiqEn,
  input  logic              tokD,
  input  logic              tokM,
  output logic              clearF,
  output excPkg::excFlush_t flush,
  output logic              irqAssert,
  output logic              fiqAssert,
  output excPkg::excVector_u vector,
  output logic              savePc,
  output logic              pcInSelect
);

  logic dataAbortCycle2;
  logic daActive;
  logic eCause;
  logic eTaken;
  logic takeFiq;
  logic intReq;

  // Second cycle of a data abort, PC save happens here
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataAbortCycle2 <= 1'b0;
    end else begin
      dataAbortCycle2 <= dataAbort;
    end
  end

  assign daActive = dataAbort | dataAbortCycle2;
  assign eCause   = prefetchAbortE | undefinedInstrE | swiE;
  // E cause loses to a data abort in flight
  assign eTaken   = eCause & ~daActive;
  assign takeFiq  = fiq & fiqEn;
  assign intReq   = takeFiq | (irq & irqEn);

  // Priority decode: data abort, E causes, FIQ, IRQ
  always_comb begin
    irqAssert = 1'b0;
    fiqAssert = 1'b0;
    clearF    = 1'b0;
    flush     = '0;
    if (daActive) begin
      // Flush E on the first cycle only, stall D meanwhile
      flush.flushD = 1'b1;
      flush.flushE = dataAbort;
      flush.flushM = 1'b1;
      flush.flushW = 1'b1;
      flush.stallD = dataAbort;
    end else if (eCause) begin
      flush.flushD = 1'b1;
      flush.flushM = 1'b1;
    end else if (intReq) begin
      // Drain token in flight until it reaches M
      clearF       = ~tokM;
      fiqAssert    = tokM & takeFiq;
      irqAssert    = tokM & ~takeFiq;
      flush.flushD = tokD & tokM;
      // Token rides through E as a bubble
      flush.flushE = tokD & ~tokM;
      flush.stallD = tokD & ~tokM;
    end
  end

  // Cause vector, one-hot among taken causes
  always_comb begin
    vector                     = '0;
    vector.cause.fiq           = fiqAssert;
    vector.cause.irq           = irqAssert;
    vector.cause.dataAbort     = dataAbortCycle2;
    vector.cause.prefetchAbort = eTaken & prefetchAbortE;
    // Undef ranks above SWI
    vector.cause.undef         = eTaken & ~prefetchAbortE & undefinedInstrE;
    vector.cause.swi           = eTaken & ~prefetchAbortE & ~undefinedInstrE & swiE;
    vector.cause.reset         = ~rstN;
  end

  assign savePc     = |vector.bits;
  assign pcInSelect = eTaken | dataAbortCycle2;

endmodule

//--- rtl/pipeClearTracker.sv
`timescale 1ns/1ps

module pipeClearTracker (
  input  logic              clk,
  input  logic              rstN,
  input  logic              clearF,
  input  excPkg::excFlush_t flush,
  output logic              tokD,
  output logic              tokM
);

  logic tokE;
  logic drainDone;

  // Token at M means all older instructions have retired
  assign drainDone = tokM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      tokD <= 1'b0;
      tokE <= 1'b0;
      tokM <= 1'b0;
    end else if (drainDone) begin
      // Entry taken, restart from empty
      tokD <= 1'b0;
      tokE <= 1'b0;
      tokM <= 1'b0;
    end else begin
      tokD <= clearF;
      // E flush leaves the token alone
      // M flush kills whatever was in E
      if (flush.flushM) begin
        tokE <= 1'b0;
      end else begin
        tokE <= tokD;
      end
      tokM <= tokE;
    end
  end

endmodule

//--- rtl/excCsrApb.sv
`timescale 1ns/1ps
`include "excCtrl_settings.svh"

module excCsrApb (
  input  logic               clk,
  input  logic               rstN,
  input  excPkg::apbReq_t    apbReq,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               irqAssert,
  input  logic               fiqAssert,
  input  excPkg::excVector_u vector,
  input  logic               savePc,
  output logic               irqEn,
  output logic               fiqEn
);

  logic                    access;
  logic                    wrAccess;
  logic                    addrOk;
  logic                    wrCtrl;
  logic                    wrCount;
  logic                    entry;
  logic [6:0]              causeReg;
  logic [`EXC_COUNT_W-1:0] countReg;

  // Access phase, always completes in one cycle
  assign access   = apbReq.psel & apbReq.penable;
  assign wrAccess = access & apbReq.pwrite;
  assign pready   = 1'b1;

  assign addrOk = (apbReq.paddr == `EXC_REG_CTRL) ||
                  (apbReq.paddr == `EXC_REG_CAUSE) ||
                  (apbReq.paddr == `EXC_REG_COUNT);

  // Unknown offset or write to read-only CAUSE
  assign pslverr = access & (~addrOk |
                   (apbReq.pwrite & (apbReq.paddr == `EXC_REG_CAUSE)));

  assign wrCtrl  = wrAccess & (apbReq.paddr == `EXC_REG_CTRL);
  assign wrCount = wrAccess & (apbReq.paddr == `EXC_REG_COUNT);

  // Real entry, reset vector bit excluded
  assign entry = savePc & (|vector.bits[6:1]);

  // Enable bits, hardware masking beats a software write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      irqEn <= 1'b0;
      fiqEn <= 1'b0;
    end else if (fiqAssert) begin
      irqEn <= 1'b0;
      fiqEn <= 1'b0;
    end else if (irqAssert) begin
      irqEn <= 1'b0;
    end else if (wrCtrl) begin
      irqEn <= apbReq.pwdata[0];
      fiqEn <= apbReq.pwdata[1];
    end
  end

  // Last cause taken
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      causeReg <= '0;
    end else if (entry) begin
      causeReg <= vector.bits;
    end
  end

  // Entry counter, saturates at all ones
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      countReg <= '0;
    end else if (wrCount) begin
      // Any write value clears it
      countReg <= '0;
    end else if (entry && (countReg != {`EXC_COUNT_W{1'b1}})) begin
      countReg <= countReg + 1'b1;
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (apbReq.psel && !apbReq.pwrite) begin
      case (apbReq.paddr)
        `EXC_REG_CTRL:  prdata = {30'b0, fiqEn, irqEn};
        `EXC_REG_CAUSE: prdata = {25'b0, causeReg};
        `EXC_REG_COUNT: prdata = {{(32-`EXC_COUNT_W){1'b0}}, countReg};
        default:        prdata = '0;
      endcase
    end
  end

endmodule

//--- rtl/excTop.sv
`timescale 1ns/1ps

module excTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              undefinedInstrE,
  input  logic              swiE,
  input  logic              prefetchAbortE,
  input  logic              dataAbort,
  input  logic              irq,
  input  logic              fiq,
  input  excPkg::apbReq_t   apbReq,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output excPkg::excFlush_t flush,
  output logic [6:0]        pcVector,
  output logic              savePc,
  output logic              pcInSelect
);

  // Enables from the register block
  logic irqEn;
  logic fiqEn;
  // Drain token handshake with the tracker
  logic clearF;
  logic tokD;
  logic tokM;
  logic irqAssert;
  logic fiqAssert;
  excPkg::excVector_u vector;

  exceptionHandler u_handler (
    .clk             (clk),
    .rstN            (rstN),
    .undefinedInstrE (undefinedInstrE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .irqEn           (irqEn),
    .fiqEn           (fiqEn),
    .tokD            (tokD),
    .tokM            (tokM),
    .clearF          (clearF),
    .flush           (flush),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert),
    .vector          (vector),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect)
  );

  pipeClearTracker u_tracker (
    .clk    (clk),
    .rstN   (rstN),
    .clearF (clearF),
    .flush  (flush),
    .tokD   (tokD),
    .tokM   (tokM)
  );

  excCsrApb u_csr (
    .clk       (clk),
    .rstN      (rstN),
    .apbReq    (apbReq),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .irqAssert (irqAssert),
    .fiqAssert (fiqAssert),
    .vector    (vector),
    .savePc    (savePc),
    .irqEn     (irqEn),
    .fiqEn     (fiqEn)
  );

  // Raw word out to the PC logic
  assign pcVector = vector.bits;

endmodule

//--- dv/excTb.sv
`timescale 1ns/1ps
`include "excCtrl_settings.svh"

module excTb;

  logic               clk;
  logic               rstN;
  logic               undefinedInstrE;
  logic               swiE;
  logic               prefetchAbortE;
  logic               dataAbort;
  logic               irq;
  logic               fiq;
  excPkg::apbReq_t    apbReq;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  excPkg::excFlush_t  flush;
  logic [6:0]         pcVector;
  logic               savePc;
  logic               pcInSelect;

  // Vector table with one entry per step
  string       nameQ[$];
  string       opQ[$];
  logic [63:0] valQ[$];
  int          offQ[$];
  logic [63:0] expQ[$];
  logic        loaded = 1'b0;

  int     cycleCnt = 0;
  int     holdStart = 0;
  int     passCount = 0;
  int     failCount = 0;
  integer seed;

  excTop i_dut (
    .clk             (clk),
    .rstN            (rstN),
    .undefinedInstrE (undefinedInstrE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .apbReq          (apbReq),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .flush           (flush),
    .pcVector        (pcVector),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Edge count used as base for interrupt offsets
  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
  end

  // Pipeline side as {flush, savePc, pcInSelect, pcVector}
  function automatic logic [63:0] observe;
    return {50'b0, flush, savePc, pcInSelect, pcVector};
  endfunction

  task automatic checkResult(input string name, input logic [63:0] expVal,
                             input logic [63:0] actVal);
    if (actVal === expVal) begin
      passCount++;
      $display("Pass %s expected %0h actual %0h", name, expVal, actVal);
    end else begin
      failCount++;
      $display("Fail %s expected %0h actual %0h", name, expVal, actVal);
    end
  endtask

  task automatic loadVectors(input int fd);
    string       line;
    string       name;
    string       op;
    logic [63:0] val;
    logic [63:0] expVal;
    int          off;
    int          n;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip column notes and blank lines
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %d %h", name, op, val, off, expVal);
        if (n == 5) begin
          nameQ.push_back(name);
          opQ.push_back(op);
          valQ.push_back(val);
          offQ.push_back(off);
          expQ.push_back(expVal);
        end
      end
    end
  endtask

  // One-cycle cause pulse sampled offset cycles in
  task automatic pulseCause(input logic [3:0] mask, input int offset,
                            output logic [63:0] act);
    @(posedge clk);
    {dataAbort, prefetchAbortE, swiE, undefinedInstrE} <= mask;
    if (offset == 0) begin
      @(negedge clk);
      act = observe();
      @(posedge clk);
      {dataAbort, prefetchAbortE, swiE, undefinedInstrE} <= 4'b0;
    end else begin
      @(posedge clk);
      {dataAbort, prefetchAbortE, swiE, undefinedInstrE} <= 4'b0;
      repeat (offset - 1) @(posedge clk);
      @(negedge clk);
      act = observe();
    end
  endtask

  // Interrupt levels stay put and the offset counts from the last change
  task automatic holdInterrupts(input logic [1:0] lines, input int offset,
                                output logic [63:0] act, output logic late);
    late = 1'b0;
    @(posedge clk);
    if (lines != {fiq, irq}) begin
      {fiq, irq} <= lines;
      holdStart = cycleCnt;
    end
    if (cycleCnt > holdStart + offset) begin
      late = 1'b1;
    end
    while (cycleCnt < holdStart + offset) begin
      @(posedge clk);
    end
    @(negedge clk);
    act = observe();
  endtask

  // Setup then access with {pslverr, prdata} as result
  task automatic apbAccess(input logic wr, input logic [`EXC_APB_ADDR_W-1:0] addr,
                           input logic [31:0] data, output logic [63:0] res);
    @(posedge clk);
    apbReq.psel    <= 1'b1;
    apbReq.penable <= 1'b0;
    apbReq.pwrite  <= wr;
    apbReq.paddr   <= addr;
    apbReq.pwdata  <= data;
    @(posedge clk);
    apbReq.penable <= 1'b1;
    @(negedge clk);
    res = {31'b0, pslverr, prdata};
    if (pready !== 1'b1) begin
      failCount++;
      $display("APB access to offset %0h saw pready low in the access phase", addr);
    end
    // Bus goes idle on the completing edge
    @(posedge clk);
    apbReq <= '0;
  endtask

  // Random COUNT reads with random gaps while the count stays put
  task automatic readNoise(input string name, input logic [63:0] expVal);
    int          reads;
    int          gap;
    int          i;
    logic [63:0] res;
    reads = 1 + int'($unsigned($random(seed)) % 4);
    for (i = 0; i < reads; i++) begin
      gap = int'($unsigned($random(seed)) % 4);
      repeat (gap) @(posedge clk);
      apbAccess(1'b0, `EXC_REG_COUNT, 32'b0, res);
      checkResult(name, expVal, res);
    end
  endtask

  task automatic runStep(input int idx);
    logic [63:0] act;
    logic        late;
    if (opQ[idx] == "pipe") begin
      pulseCause(valQ[idx][3:0], offQ[idx], act);
      checkResult(nameQ[idx], expQ[idx], act);
    end else if (opQ[idx] == "hold") begin
      holdInterrupts(valQ[idx][1:0], offQ[idx], act, late);
      if (late) begin
        failCount++;
        $display("Step %s could not be sampled, offset %0d was already past",
                 nameQ[idx], offQ[idx]);
      end else begin
        checkResult(nameQ[idx], expQ[idx], act);
      end
    end else if (opQ[idx] == "wr" || opQ[idx] == "rd") begin
      apbAccess(opQ[idx] == "wr", valQ[idx][32 +: `EXC_APB_ADDR_W], valQ[idx][31:0], act);
      checkResult(nameQ[idx], expQ[idx], act);
    end else if (opQ[idx] == "noise") begin
      readNoise(nameQ[idx], expQ[idx]);
    end else begin
      failCount++;
      $display("Step %s has unknown operation %s", nameQ[idx], opQ[idx]);
    end
  endtask

  initial begin
    int          fd;
    logic [63:0] act;
    rstN = 1'b0;
    {dataAbort, prefetchAbortE, swiE, undefinedInstrE} = 4'b0;
    irq = 1'b0;
    fiq = 1'b0;
    apbReq = '0;
    seed = 32'hd97e7c71;
    fd = $fopen("dv/excVectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/excVectors.txt");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      loadVectors(fd);
      $fclose(fd);
      loaded = 1'b1;
      repeat (15) @(posedge clk);
      // In reset only savePc and the reset vector bit are high
      @(negedge clk);
      act = observe();
      checkResult("rstVector", 64'h101, act);
      @(posedge clk);
      rstN <= 1'b1;
      foreach (nameQ[idx]) begin
        runStep(idx);
      end
      $display("Checks: %0d passed, %0d failed, %0d steps", passCount, failCount,
               nameQ.size());
      if (failCount == 0 && passCount > 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // 40 cycles per step on top of reset
  initial begin
    wait (loaded);
    repeat (16 + 40 * nameQ.size()) @(posedge clk);
    $display("Watchdog expired, steps did not finish in %0d cycles",
             16 + 40 * nameQ.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- dv/excVectors.txt
# name op value offset expected; value and expected in hex, offset in cycles
# pipe mask undef=1 swi=2 pabt=4 dabt=8; hold irq=1 fiq=2; wr/rd value is addr<<32|data
rstIdle     pipe  0         0  0
rstCtrl     rd    000000000 0  0
rstCause    rd    400000000 0  0
rstCount    rd    800000000 0  0
rstNoise    noise 0         0  0
swiEntry    pipe  2         0  2984
swiCause    rd    400000000 0  4
swiCount    rd    800000000 0  1
undefEntry  pipe  1         0  2982
undefCause  rd    400000000 0  2
undefCount  rd    800000000 0  2
pabtEntry   pipe  4         0  2988
pabtCause   rd    400000000 0  8
pabtCount   rd    800000000 0  3
dabtFlush   pipe  8         0  3e00
dabtSave    pipe  8         1  2d90
dabtCause   rd    400000000 0  10
dabtCount   rd    800000000 0  5
idleNoise   noise 0         0  5
irqEnable   wr    000000001 0  0
irqCtrl     rd    000000000 0  1
irqWait     hold  1         0  0
irqDrain1   hold  1         1  1200
irqDrain2   hold  1         2  1200
irqTaken    hold  1         3  2120
irqDone     hold  1         4  0
irqMasked   rd    000000000 0  0
irqCause    rd    400000000 0  20
irqQuiet    hold  1         16 0
irqNoRetake rd    800000000 0  6
irqRelease  hold  0         0  0
bothEnable  wr    000000003 0  0
fiqWait     hold  3         0  0
fiqDrain    hold  3         2  1200
fiqTaken    hold  3         3  2140
fiqMasked   rd    000000000 0  0
fiqCause    rd    400000000 0  40
fiqRelease  hold  0         0  0
raceFlush   pipe  9         0  3e00
raceSave    pipe  9         1  2d90
badOffset   rd    c00000000 0  100000000
causeWrite  wr    400000000 0  100000000
countClear  wr    800000000 0  0
countZero   rd    800000000 0  0

//--- files.f
+incdir+rtl
rtl/excPkg.sv
rtl/exceptionHandler.sv
rtl/pipeClearTracker.sv
rtl/excCsrApb.sv
rtl/excTop.sv
dv/excTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= excTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST) dv/excVectors.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	@out="$$($(SIMBIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
